// File: rtl/rv_dec_pkg.sv
/* Shared widths, RV32I major opcodes, instruction word views,
   decode enumerations and the immediate generator */
package rv_dec_pkg;

  localparam int XLEN     = 32;
  localparam int REG_AW   = 5;
  localparam int FQ_DEPTH = 4;
  localparam int FQ_AW    = $clog2(FQ_DEPTH);

  // Major opcodes, bits [6:0]
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]       imm12;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } i_type_t;

  // Same 32-bit word, two field layouts
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

  typedef enum logic [1:0] {
    SRC_ZERO,
    SRC_REG,
    SRC_IMM,
    SRC_PC
  } op_src_e;

  typedef enum logic [1:0] {
    LSU_NONE,
    LSU_LOAD,
    LSU_STORE
  } lsu_op_e;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_e;

  // Sign-extended immediate for the given encoding format
  function automatic logic [XLEN-1:0] gen_imm(input logic [XLEN-1:0] word,
                                              input imm_fmt_e fmt);
    logic [XLEN-1:0] imm;
    case (fmt)
      IMM_I: imm = {{20{word[31]}}, word[31:20]};
      IMM_S: imm = {{20{word[31]}}, word[31:25], word[11:7]};
      IMM_B: imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
      IMM_U: imm = {word[31:12], 12'b0};
      IMM_J: imm = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
      default: imm = '0;
    endcase
    return imm;
  endfunction

endpackage

// File: rtl/fetch_queue.sv
/* Four-entry instruction word FIFO with valid/ready on both sides and flush */
`timescale 1ns/1ns

module fetch_queue (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               push_valid_i,
  input  rv_dec_pkg::instr_u push_instr_i,
  output logic               push_ready_o,
  input  logic               flush_i,
  input  logic               pop_i,
  output logic               head_valid_o,
  output rv_dec_pkg::instr_u head_instr_o
);

  rv_dec_pkg::instr_u                 mem [rv_dec_pkg::FQ_DEPTH];
  logic [rv_dec_pkg::FQ_AW-1:0]       wr_ptr_q;
  logic [rv_dec_pkg::FQ_AW-1:0]       rd_ptr_q;
  logic [rv_dec_pkg::FQ_AW:0]         count_q;
  logic                               do_push;
  logic                               do_pop;

  assign push_ready_o = (count_q != rv_dec_pkg::FQ_DEPTH);
  assign head_valid_o = (count_q != '0);
  assign head_instr_o = mem[rd_ptr_q];

  // Flush wins over both sides in the same cycle
  assign do_push = push_valid_i && push_ready_o && !flush_i;
  assign do_pop  = pop_i && head_valid_o && !flush_i;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_instr_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // The decoder only pops a word that is there
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
    pop_i |-> head_valid_o)
    else $error("pop from empty fetch queue");

endmodule

// File: rtl/instr_decode.sv
/* Registered RV32I decoder: control fields, immediate, pc tracking,
   illegal opcode flag, stall and jump handling */
`timescale 1ns/1ns

module instr_decode (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                head_valid_i,
  input  rv_dec_pkg::instr_u                  head_instr_i,
  input  logic                                jump_i,
  input  logic [rv_dec_pkg::XLEN-1:0]         pc_jump_i,
  input  logic [rv_dec_pkg::XLEN-1:0]         pc_reset_i,
  input  logic                                id_ready_i,
  output logic                                pop_o,
  output logic                                id_valid_o,
  output logic [rv_dec_pkg::XLEN-1:0]         pc_o,
  output logic [rv_dec_pkg::REG_AW-1:0]       rd_addr_o,
  output logic [rv_dec_pkg::REG_AW-1:0]       rs1_addr_o,
  output logic [rv_dec_pkg::REG_AW-1:0]       rs2_addr_o,
  output logic [rv_dec_pkg::XLEN-1:0]         imm_o,
  output logic [2:0]                          funct3_o,
  output logic                                alt_op_o,
  output rv_dec_pkg::op_src_e                 rs1_src_o,
  output rv_dec_pkg::op_src_e                 rs2_src_o,
  output logic                                we_rd_o,
  output rv_dec_pkg::lsu_op_e                 lsu_op_o,
  output logic                                jump_o,
  output logic                                branch_o,
  output logic                                illegal_o
);

  logic [rv_dec_pkg::XLEN-1:0] word;
  logic [rv_dec_pkg::XLEN-1:0] imm_d;
  logic [2:0]                  funct3_d;
  logic                        alt_op_d;
  rv_dec_pkg::op_src_e         rs1_src_d;
  rv_dec_pkg::op_src_e         rs2_src_d;
  logic                        we_rd_d;
  rv_dec_pkg::lsu_op_e         lsu_op_d;
  logic                        jump_d;
  logic                        branch_d;
  logic                        illegal_d;
  logic                        is_shift;
  logic [rv_dec_pkg::XLEN-1:0] pc_next_q;
  logic                        pc_init_q;
  logic [rv_dec_pkg::XLEN-1:0] pc_sel;

  assign word     = head_instr_i;
  // SLLI/SRLI/SRAI carry funct7 in the upper immediate bits
  assign is_shift = (head_instr_i.i.funct3 == 3'b001) || (head_instr_i.i.funct3 == 3'b101);

  always_comb begin
    imm_d     = '0;
    funct3_d  = 3'b000;
    alt_op_d  = 1'b0;
    rs1_src_d = rv_dec_pkg::SRC_ZERO;
    rs2_src_d = rv_dec_pkg::SRC_ZERO;
    we_rd_d   = 1'b0;
    lsu_op_d  = rv_dec_pkg::LSU_NONE;
    jump_d    = 1'b0;
    branch_d  = 1'b0;
    illegal_d = 1'b0;
    case (head_instr_i.r.opcode)
      rv_dec_pkg::OPC_OP_IMM: begin
        funct3_d  = head_instr_i.i.funct3;
        rs1_src_d = rv_dec_pkg::SRC_REG;
        rs2_src_d = rv_dec_pkg::SRC_IMM;
        imm_d     = rv_dec_pkg::gen_imm(word, rv_dec_pkg::IMM_I);
        alt_op_d  = is_shift && head_instr_i.r.funct7[5];
        we_rd_d   = 1'b1;
      end
      rv_dec_pkg::OPC_LUI, rv_dec_pkg::OPC_AUIPC: begin
        rs1_src_d = (head_instr_i.r.opcode == rv_dec_pkg::OPC_LUI) ?
                    rv_dec_pkg::SRC_ZERO : rv_dec_pkg::SRC_PC;
        rs2_src_d = rv_dec_pkg::SRC_IMM;
        imm_d     = rv_dec_pkg::gen_imm(word, rv_dec_pkg::IMM_U);
        we_rd_d   = 1'b1;
      end
      rv_dec_pkg::OPC_OP: begin
        funct3_d  = head_instr_i.r.funct3;
        rs1_src_d = rv_dec_pkg::SRC_REG;
        rs2_src_d = rv_dec_pkg::SRC_REG;
        alt_op_d  = head_instr_i.r.funct7[5];
        we_rd_d   = 1'b1;
      end
      rv_dec_pkg::OPC_JAL: begin
        jump_d    = 1'b1;
        rs1_src_d = rv_dec_pkg::SRC_PC;
        rs2_src_d = rv_dec_pkg::SRC_IMM;
        imm_d     = rv_dec_pkg::gen_imm(word, rv_dec_pkg::IMM_J);
        we_rd_d   = 1'b1;
      end
      rv_dec_pkg::OPC_JALR: begin
        jump_d    = 1'b1;
        rs1_src_d = rv_dec_pkg::SRC_REG;
        rs2_src_d = rv_dec_pkg::SRC_IMM;
        imm_d     = rv_dec_pkg::gen_imm(word, rv_dec_pkg::IMM_I);
        we_rd_d   = 1'b1;
      end
      rv_dec_pkg::OPC_BRANCH: begin
        branch_d  = 1'b1;
        funct3_d  = head_instr_i.r.funct3;
        rs1_src_d = rv_dec_pkg::SRC_REG;
        rs2_src_d = rv_dec_pkg::SRC_REG;
        imm_d     = rv_dec_pkg::gen_imm(word, rv_dec_pkg::IMM_B);
      end
      // funct3 carries the access width for loads and stores
      rv_dec_pkg::OPC_LOAD: begin
        lsu_op_d  = rv_dec_pkg::LSU_LOAD;
        funct3_d  = head_instr_i.i.funct3;
        rs1_src_d = rv_dec_pkg::SRC_REG;
        rs2_src_d = rv_dec_pkg::SRC_IMM;
        imm_d     = rv_dec_pkg::gen_imm(word, rv_dec_pkg::IMM_I);
        we_rd_d   = 1'b1;
      end
      rv_dec_pkg::OPC_STORE: begin
        lsu_op_d  = rv_dec_pkg::LSU_STORE;
        funct3_d  = head_instr_i.r.funct3;
        rs1_src_d = rv_dec_pkg::SRC_REG;
        rs2_src_d = rv_dec_pkg::SRC_IMM;
        imm_d     = rv_dec_pkg::gen_imm(word, rv_dec_pkg::IMM_S);
      end
      rv_dec_pkg::OPC_MISC_MEM: begin
        funct3_d = 3'b000;
      end
      rv_dec_pkg::OPC_SYSTEM: begin
        // CSR address rides in the I immediate
        imm_d = rv_dec_pkg::gen_imm(word, rv_dec_pkg::IMM_I);
        if (head_instr_i.i.funct3 != 3'b000) begin
          rs1_src_d = rv_dec_pkg::SRC_REG;
          we_rd_d   = (head_instr_i.i.rd != '0);
        end
      end
      default: begin
        illegal_d = 1'b1;
      end
    endcase
  end

  assign pop_o  = head_valid_i && (!id_valid_o || id_ready_i) && !jump_i;
  assign pc_sel = pc_init_q ? pc_reset_i : pc_next_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_valid_o <= 1'b0;
      we_rd_o    <= 1'b0;
      lsu_op_o   <= rv_dec_pkg::LSU_NONE;
      jump_o     <= 1'b0;
      branch_o   <= 1'b0;
      illegal_o  <= 1'b0;
      pc_init_q  <= 1'b1;
      pc_next_q  <= '0;
    end else if (jump_i) begin
      id_valid_o <= 1'b0;
      pc_init_q  <= 1'b0;
      pc_next_q  <= pc_jump_i;
    end else if (pop_o) begin
      id_valid_o <= 1'b1;
      we_rd_o    <= we_rd_d;
      lsu_op_o   <= lsu_op_d;
      jump_o     <= jump_d;
      branch_o   <= branch_d;
      illegal_o  <= illegal_d;
      pc_init_q  <= 1'b0;
      pc_next_q  <= pc_sel + rv_dec_pkg::XLEN'(4);
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      pc_o       <= pc_sel;
      rd_addr_o  <= head_instr_i.i.rd;
      rs1_addr_o <= head_instr_i.i.rs1;
      rs2_addr_o <= head_instr_i.r.rs2;
      imm_o      <= imm_d;
      funct3_o   <= funct3_d;
      alt_op_o   <= alt_op_d;
      rs1_src_o  <= rs1_src_d;
      rs2_src_o  <= rs2_src_d;
    end
  end

  // Back-pressure holds the presented instruction
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    id_valid_o && !id_ready_i && !jump_i |=>
      id_valid_o && $stable({pc_o, rd_addr_o, rs1_addr_o, rs2_addr_o, imm_o, funct3_o,
                             alt_op_o, rs1_src_o, rs2_src_o, we_rd_o, lsu_op_o,
                             jump_o, branch_o, illegal_o}))
    else $error("decode outputs changed under back-pressure");

endmodule

// File: rtl/register_file.sv
/* 32 x 32-bit register file, two registered read ports, one write port */
`timescale 1ns/1ns

module register_file (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [rv_dec_pkg::REG_AW-1:0] rs1_addr_i,
  input  logic [rv_dec_pkg::REG_AW-1:0] rs2_addr_i,
  input  logic                          re_i,
  input  logic                          we_i,
  input  logic [rv_dec_pkg::REG_AW-1:0] rd_addr_i,
  input  logic [rv_dec_pkg::XLEN-1:0]   rd_data_i,
  output logic [rv_dec_pkg::XLEN-1:0]   rs1_data_o,
  output logic [rv_dec_pkg::XLEN-1:0]   rs2_data_o
);

  // x0 has no storage
  logic [rv_dec_pkg::XLEN-1:0] regs [1:31];
  logic                        wr_en;

  assign wr_en = we_i && (rd_addr_i != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // Same-edge write to a read address is forwarded
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rs1_data_o <= '0;
      rs2_data_o <= '0;
    end else if (re_i) begin
      rs1_data_o <= (rs1_addr_i == '0) ? '0 :
                    (wr_en && rd_addr_i == rs1_addr_i) ? rd_data_i : regs[rs1_addr_i];
      rs2_data_o <= (rs2_addr_i == '0) ? '0 :
                    (wr_en && rd_addr_i == rs2_addr_i) ? rd_data_i : regs[rs2_addr_i];
    end
  end

  // A value written to x1..x31 comes back on the next read
  a_read_back: assert property (@(posedge clk) disable iff (!rst_n_i)
    re_i && !wr_en && $past(wr_en) && (rs1_addr_i == $past(rd_addr_i)) |=>
      rs1_data_o == $past(rd_data_i, 2))
    else $error("register read did not return the last written value");

endmodule

// File: rtl/decode_stage_top.sv
/* Decode stage top: fetch queue, decoder and register file */
`timescale 1ns/1ns

module decode_stage_top (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          fetch_valid_i,
  input  logic [rv_dec_pkg::XLEN-1:0]   fetch_instr_i,
  output logic                          fetch_ready_o,
  input  logic                          jump_i,
  input  logic [rv_dec_pkg::XLEN-1:0]   pc_jump_i,
  input  logic [rv_dec_pkg::XLEN-1:0]   pc_reset_i,
  input  logic                          wb_we_i,
  input  logic [rv_dec_pkg::REG_AW-1:0] wb_rd_addr_i,
  input  logic [rv_dec_pkg::XLEN-1:0]   wb_rd_data_i,
  input  logic                          id_ready_i,
  output logic                          id_valid_o,
  output logic [rv_dec_pkg::XLEN-1:0]   pc_o,
  output logic [rv_dec_pkg::REG_AW-1:0] rd_addr_o,
  output logic [rv_dec_pkg::REG_AW-1:0] rs1_addr_o,
  output logic [rv_dec_pkg::REG_AW-1:0] rs2_addr_o,
  output logic [rv_dec_pkg::XLEN-1:0]   imm_o,
  output logic [2:0]                    funct3_o,
  output logic                          alt_op_o,
  output rv_dec_pkg::op_src_e           rs1_src_o,
  output rv_dec_pkg::op_src_e           rs2_src_o,
  output logic                          we_rd_o,
  output rv_dec_pkg::lsu_op_e           lsu_op_o,
  output logic                          jump_o,
  output logic                          branch_o,
  output logic                          illegal_o,
  output logic [rv_dec_pkg::XLEN-1:0]   rs1_data_o,
  output logic [rv_dec_pkg::XLEN-1:0]   rs2_data_o
);

  logic               head_valid;
  rv_dec_pkg::instr_u head_instr;
  logic               pop;

  fetch_queue i_fetch_queue (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .push_valid_i (fetch_valid_i),
    .push_instr_i (fetch_instr_i),
    .push_ready_o (fetch_ready_o),
    .flush_i      (jump_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_instr_o (head_instr)
  );

  instr_decode i_instr_decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .head_valid_i (head_valid),
    .head_instr_i (head_instr),
    .jump_i       (jump_i),
    .pc_jump_i    (pc_jump_i),
    .pc_reset_i   (pc_reset_i),
    .id_ready_i   (id_ready_i),
    .pop_o        (pop),
    .id_valid_o   (id_valid_o),
    .pc_o         (pc_o),
    .rd_addr_o    (rd_addr_o),
    .rs1_addr_o   (rs1_addr_o),
    .rs2_addr_o   (rs2_addr_o),
    .imm_o        (imm_o),
    .funct3_o     (funct3_o),
    .alt_op_o     (alt_op_o),
    .rs1_src_o    (rs1_src_o),
    .rs2_src_o    (rs2_src_o),
    .we_rd_o      (we_rd_o),
    .lsu_op_o     (lsu_op_o),
    .jump_o       (jump_o),
    .branch_o     (branch_o),
    .illegal_o    (illegal_o)
  );

  // Operands are read from the head word in the pop cycle
  register_file i_register_file (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (head_instr.r.rs1),
    .rs2_addr_i (head_instr.r.rs2),
    .re_i       (pop),
    .we_i       (wb_we_i),
    .rd_addr_i  (wb_rd_addr_i),
    .rd_data_i  (wb_rd_data_i),
    .rs1_data_o (rs1_data_o),
    .rs2_data_o (rs2_data_o)
  );

endmodule

// File: verif/dec_checker.sv
/* Decode stage checker: reference decoder, expected word queue,
   model register file and model pc */
`timescale 1ns/1ns

module dec_checker (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          fetch_valid_i, fetch_ready_o, jump_i, wb_we_i,
  input  logic                          id_ready_i, id_valid_o,
  input  logic [rv_dec_pkg::XLEN-1:0]   fetch_instr_i, pc_jump_i, pc_reset_i, wb_rd_data_i,
  input  logic [rv_dec_pkg::REG_AW-1:0] wb_rd_addr_i, rd_addr_o, rs1_addr_o, rs2_addr_o,
  input  logic [rv_dec_pkg::XLEN-1:0]   pc_o, imm_o, rs1_data_o, rs2_data_o,
  input  logic [2:0]                    funct3_o,
  input  logic                          alt_op_o, we_rd_o, jump_o, branch_o, illegal_o,
  input  rv_dec_pkg::op_src_e           rs1_src_o, rs2_src_o,
  input  rv_dec_pkg::lsu_op_e           lsu_op_o,
  output int                            pending_o, checked_o, errors_o
);

  typedef struct packed {
    logic [31:0]         imm;
    logic [2:0]          funct3;
    logic                alt_op;
    rv_dec_pkg::op_src_e rs1_src;
    rv_dec_pkg::op_src_e rs2_src;
    logic                we_rd;
    rv_dec_pkg::lsu_op_e lsu_op;
    logic                jump;
    logic                branch;
    logic                illegal;
  } dec_t;

  rv_dec_pkg::instr_u expq [$];
  logic [31:0]        model_regs [32];
  logic [31:0]        model_pc;
  logic               reset_checked = 1'b0;
  int                 n_pending = 0;
  int                 n_checked = 0;
  int                 n_errors = 0;

  assign pending_o = n_pending;
  assign checked_o = n_checked;
  assign errors_o  = n_errors;

  // Expected control fields, straight from the RV32I encoding tables
  function automatic dec_t ref_decode(input rv_dec_pkg::instr_u u);
    logic [31:0] b;
    dec_t        d;
    b = u;
    d = '0;
    case (u.r.opcode)
      rv_dec_pkg::OPC_OP_IMM: begin
        d = '{32'($signed(b[31:20])), b[14:12], (b[13:12] == 2'b01) && b[30],
              rv_dec_pkg::SRC_REG, rv_dec_pkg::SRC_IMM, 1'b1, rv_dec_pkg::LSU_NONE, 1'b0, 1'b0, 1'b0};
      end
      rv_dec_pkg::OPC_LUI: begin
        d = '{{b[31:12], 12'h000}, 3'b000, 1'b0, rv_dec_pkg::SRC_ZERO, rv_dec_pkg::SRC_IMM,
              1'b1, rv_dec_pkg::LSU_NONE, 1'b0, 1'b0, 1'b0};
      end
      rv_dec_pkg::OPC_AUIPC: begin
        d = '{{b[31:12], 12'h000}, 3'b000, 1'b0, rv_dec_pkg::SRC_PC, rv_dec_pkg::SRC_IMM,
              1'b1, rv_dec_pkg::LSU_NONE, 1'b0, 1'b0, 1'b0};
      end
      rv_dec_pkg::OPC_OP: begin
        d = '{32'h0, b[14:12], b[30], rv_dec_pkg::SRC_REG, rv_dec_pkg::SRC_REG,
              1'b1, rv_dec_pkg::LSU_NONE, 1'b0, 1'b0, 1'b0};
      end
      rv_dec_pkg::OPC_JAL: begin
        d = '{32'($signed({b[31], b[19:12], b[20], b[30:21], 1'b0})), 3'b000, 1'b0,
              rv_dec_pkg::SRC_PC, rv_dec_pkg::SRC_IMM, 1'b1, rv_dec_pkg::LSU_NONE, 1'b1, 1'b0, 1'b0};
      end
      rv_dec_pkg::OPC_JALR: begin
        d = '{32'($signed(b[31:20])), 3'b000, 1'b0, rv_dec_pkg::SRC_REG, rv_dec_pkg::SRC_IMM,
              1'b1, rv_dec_pkg::LSU_NONE, 1'b1, 1'b0, 1'b0};
      end
      rv_dec_pkg::OPC_BRANCH: begin
        d = '{32'($signed({b[31], b[7], b[30:25], b[11:8], 1'b0})), b[14:12], 1'b0,
              rv_dec_pkg::SRC_REG, rv_dec_pkg::SRC_REG, 1'b0, rv_dec_pkg::LSU_NONE, 1'b0, 1'b1, 1'b0};
      end
      rv_dec_pkg::OPC_LOAD: begin
        d = '{32'($signed(b[31:20])), b[14:12], 1'b0, rv_dec_pkg::SRC_REG, rv_dec_pkg::SRC_IMM,
              1'b1, rv_dec_pkg::LSU_LOAD, 1'b0, 1'b0, 1'b0};
      end
      rv_dec_pkg::OPC_STORE: begin
        d = '{32'($signed({b[31:25], b[11:7]})), b[14:12], 1'b0, rv_dec_pkg::SRC_REG,
              rv_dec_pkg::SRC_IMM, 1'b0, rv_dec_pkg::LSU_STORE, 1'b0, 1'b0, 1'b0};
      end
      rv_dec_pkg::OPC_MISC_MEM: begin
        d = '0;
      end
      rv_dec_pkg::OPC_SYSTEM: begin
        // CSR forms read rs1 and write rd unless rd is x0
        d.imm = 32'($signed(b[31:20]));
        if (b[14:12] != 3'b000) begin
          d.rs1_src = rv_dec_pkg::SRC_REG;
          d.we_rd   = (b[11:7] != 5'd0);
        end
      end
      default: d.illegal = 1'b1;
    endcase
    return d;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      n_errors++;
      $display("Fail t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic compare_head();
    rv_dec_pkg::instr_u u;
    dec_t               e;
    if (expq.size() == 0) begin
      n_errors++;
      $display("t=%0t: decoded instruction at pc %h was never fetched", $time, pc_o);
      return;
    end
    u = expq.pop_front();
    e = ref_decode(u);
    n_checked++;
    check_field("pc_o", model_pc, pc_o);
    check_field("rd_addr_o", 32'(u.r.rd), 32'(rd_addr_o));
    check_field("rs1_addr_o", 32'(u.r.rs1), 32'(rs1_addr_o));
    check_field("rs2_addr_o", 32'(u.r.rs2), 32'(rs2_addr_o));
    check_field("imm_o", e.imm, imm_o);
    check_field("funct3_o", 32'(e.funct3), 32'(funct3_o));
    check_field("alt_op_o", 32'(e.alt_op), 32'(alt_op_o));
    check_field("rs1_src_o", 32'(e.rs1_src), 32'(rs1_src_o));
    check_field("rs2_src_o", 32'(e.rs2_src), 32'(rs2_src_o));
    check_field("we_rd_o", 32'(e.we_rd), 32'(we_rd_o));
    check_field("lsu_op_o", 32'(e.lsu_op), 32'(lsu_op_o));
    check_field("jump_o", 32'(e.jump), 32'(jump_o));
    check_field("branch_o", 32'(e.branch), 32'(branch_o));
    check_field("illegal_o", 32'(e.illegal), 32'(illegal_o));
    check_field("rs1_data_o", (u.r.rs1 == 5'd0) ? 32'h0 : model_regs[u.r.rs1], rs1_data_o);
    check_field("rs2_data_o", (u.r.rs2 == 5'd0) ? 32'h0 : model_regs[u.r.rs2], rs2_data_o);
    model_pc = model_pc + 32'd4;
  endtask

  always @(posedge clk) begin
    if (!rst_n_i) begin
      expq.delete();
      model_pc = pc_reset_i;
    end else begin
      if (!reset_checked) begin
        check_field("fetch_ready_o", 32'd1, 32'(fetch_ready_o));
        check_field("id_valid_o", 32'd0, 32'(id_valid_o));
        check_field("illegal_o", 32'd0, 32'(illegal_o));
        check_field("we_rd_o", 32'd0, 32'(we_rd_o));
        check_field("jump_o", 32'd0, 32'(jump_o));
        check_field("branch_o", 32'd0, 32'(branch_o));
        reset_checked = 1'b1;
      end
      if (jump_i) begin
        // Redirect drops every word not yet consumed
        expq.delete();
        model_pc = pc_jump_i;
      end else begin
        if (id_valid_o && id_ready_i) begin
          compare_head();
        end
        if (fetch_valid_i && fetch_ready_o) begin
          expq.push_back(fetch_instr_i);
        end
      end
      if (wb_we_i && wb_rd_addr_i != 5'd0) begin
        model_regs[wb_rd_addr_i] = wb_rd_data_i;
      end
    end
    n_pending = expq.size();
  end

endmodule

// File: verif/tb_decode.sv
/* Decode stage testbench: clock, reset, fetch and writeback stimulus,
   consumer back-pressure and watchdog */
`timescale 1ns/1ns

module tb_decode;

  localparam int CLK_PERIOD = 100;
  localparam int N_LEGAL    = 40;
  localparam int N_WB       = 6;
  localparam int N_STALL    = 40;
  localparam int N_ILLEGAL  = 8;
  // Test 5 offers three words before the jump, one in it and two after it
  localparam int N_INSTR    = 1 + N_LEGAL + 2 * N_WB + N_STALL + 6 + N_ILLEGAL;

  logic                clk;
  logic                rst_n_i;
  logic                fetch_valid_i, fetch_ready_o, jump_i, wb_we_i, id_ready_i;
  logic [31:0]         fetch_instr_i, pc_jump_i, pc_reset_i, wb_rd_data_i;
  logic [4:0]          wb_rd_addr_i, rd_addr_o, rs1_addr_o, rs2_addr_o;
  logic                id_valid_o, alt_op_o, we_rd_o, jump_o, branch_o, illegal_o;
  logic [31:0]         pc_o, imm_o, rs1_data_o, rs2_data_o;
  logic [2:0]          funct3_o;
  rv_dec_pkg::op_src_e rs1_src_o, rs2_src_o;
  rv_dec_pkg::lsu_op_e lsu_op_o;
  int                  pending_o, checked_o, errors_o;
  logic                ready_random, ready_level;
  int                  base_checked, base_errors;
  logic [4:0]          wb_addr;

  decode_stage_top i_dut (.*);

  dec_checker i_chk (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic known_opcode(input logic [6:0] opc);
    return opc inside {rv_dec_pkg::OPC_OP_IMM, rv_dec_pkg::OPC_LUI, rv_dec_pkg::OPC_AUIPC,
                       rv_dec_pkg::OPC_OP, rv_dec_pkg::OPC_JAL, rv_dec_pkg::OPC_JALR,
                       rv_dec_pkg::OPC_BRANCH, rv_dec_pkg::OPC_LOAD, rv_dec_pkg::OPC_STORE,
                       rv_dec_pkg::OPC_MISC_MEM, rv_dec_pkg::OPC_SYSTEM};
  endfunction

  // Kind 0 to 10 picks one of the eleven supported major opcodes
  function automatic logic [31:0] legal_word(input int kind);
    logic [31:0] w;
    w = $urandom;
    case (kind)
      0: w[6:0] = rv_dec_pkg::OPC_OP_IMM;
      1: w[6:0] = rv_dec_pkg::OPC_LUI;
      2: w[6:0] = rv_dec_pkg::OPC_AUIPC;
      3: w[6:0] = rv_dec_pkg::OPC_OP;
      4: w[6:0] = rv_dec_pkg::OPC_JAL;
      5: w[6:0] = rv_dec_pkg::OPC_JALR;
      6: w[6:0] = rv_dec_pkg::OPC_BRANCH;
      7: w[6:0] = rv_dec_pkg::OPC_LOAD;
      8: w[6:0] = rv_dec_pkg::OPC_STORE;
      9: w[6:0] = rv_dec_pkg::OPC_MISC_MEM;
      default: w[6:0] = rv_dec_pkg::OPC_SYSTEM;
    endcase
    // OP and immediate shifts only allow funct7 of 0x00 or 0x20
    if (w[6:0] == rv_dec_pkg::OPC_OP ||
        (w[6:0] == rv_dec_pkg::OPC_OP_IMM && w[13:12] == 2'b01)) begin
      w[31:25] = {1'b0, w[30], 5'b00000};
    end
    if (w[6:0] == rv_dec_pkg::OPC_JALR) begin
      w[14:12] = 3'b000;
    end
    return w;
  endfunction

  function automatic logic [31:0] illegal_word();
    logic [31:0] w;
    do begin
      w = $urandom;
    end while (known_opcode(w[6:0]));
    return w;
  endfunction

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send_word(input logic [31:0] w);
    fetch_valid_i = 1'b1;
    fetch_instr_i = w;
    while (!fetch_ready_o) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    wb_we_i      = 1'b1;
    wb_rd_addr_i = addr;
    wb_rd_data_i = data;
    @(negedge clk);
    wb_we_i = 1'b0;
  endtask

  task automatic wait_drained();
    fetch_valid_i = 1'b0;
    while (pending_o != 0) @(negedge clk);
  endtask

  task automatic drive_ready();
    forever begin
      @(negedge clk);
      id_ready_i = ready_random ? 1'($urandom_range(1, 0)) : ready_level;
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d instructions checked, %0d errors", num, name,
             checked_o - base_checked, errors_o - base_errors);
    base_checked = checked_o;
    base_errors  = errors_o;
  endtask

  initial begin
    #((N_INSTR * 20 + 200) * CLK_PERIOD);
    $display("Watchdog expired: decode stage stopped making progress");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(32'h7c67));
    clk           = 1'b0;
    rst_n_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    jump_i        = 1'b0;
    pc_jump_i     = '0;
    pc_reset_i    = 32'h0000_0200;
    wb_we_i       = 1'b0;
    wb_rd_addr_i  = '0;
    wb_rd_data_i  = '0;
    id_ready_i    = 1'b0;
    ready_random  = 1'b0;
    ready_level   = 1'b1;
    base_checked  = 0;
    base_errors   = 0;
    fork
      drive_ready();
    join_none
    repeat (10) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);

    // Known contents in every register before any operand read
    for (int r = 1; r < 32; r++) begin
      write_reg(5'(r), $urandom);
    end
    send_word(legal_word($urandom_range(10, 0)));
    wait_drained();
    report_test(1, "reset state and first pc");

    // Every major opcode comes round in turn
    for (int i = 0; i < N_LEGAL; i++) begin
      send_word(legal_word(i % 11));
    end
    wait_drained();
    report_test(2, "random legal words");

    for (int i = 0; i < N_WB; i++) begin
      wb_addr = (i == 0) ? 5'd0 : 5'($urandom_range(31, 1));
      write_reg(wb_addr, $urandom);
      send_word({7'b0, 5'($urandom), wb_addr, 3'b000, 5'($urandom), rv_dec_pkg::OPC_OP});
      send_word({7'b0, wb_addr, 5'($urandom), 3'b000, 5'($urandom), rv_dec_pkg::OPC_OP});
      wait_drained();
    end
    report_test(3, "writeback then read");

    ready_random = 1'b1;
    repeat (N_STALL) send_word(legal_word($urandom_range(10, 0)));
    wait_drained();
    ready_random = 1'b0;
    report_test(4, "random back-pressure");

    // Hold the consumer so the jump finds words in flight
    ready_level = 1'b0;
    repeat (3) send_word(legal_word($urandom_range(10, 0)));
    jump_i        = 1'b1;
    pc_jump_i     = $urandom & 32'hffff_fffc;
    fetch_instr_i = legal_word($urandom_range(10, 0));
    @(negedge clk);
    jump_i        = 1'b0;
    fetch_valid_i = 1'b0;
    ready_level   = 1'b1;
    repeat (2) send_word(legal_word($urandom_range(10, 0)));
    wait_drained();
    report_test(5, "jump redirect");

    repeat (N_ILLEGAL) send_word(illegal_word());
    wait_drained();
    report_test(6, "unsupported opcodes");

    $display("tests 6, instructions checked %0d, errors %0d", checked_o, errors_o);
    if (errors_o == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: src.f
rtl/rv_dec_pkg.sv
rtl/fetch_queue.sv
rtl/instr_decode.sv
rtl/register_file.sv
rtl/decode_stage_top.sv
verif/dec_checker.sv
verif/tb_decode.sv

// File: Makefile
SIM := obj_dir/Vtb_decode

.PHONY: all run check clean

all: run

$(SIM): src.f $(shell cat src.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_decode -f src.f

run: $(SIM)
	$(SIM) > sim.log; cat sim.log
	grep -q "=== PASS ===" sim.log

check:
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
